// ==== tile_cfg.svh ====
////////////////////////////////////////////////////////////
// Tile configuration constants for the mesh tile
// Include before any use of coordinate, address or data widths
////////////////////////////////////////////////////////////

`ifndef TILE_CFG_SVH
`define TILE_CFG_SVH

// Bits per mesh coordinate, 4x4 mesh
`define TILE_COORD_W 2

// Scratchpad word address
`define TILE_ADDR_W 6

// Data word
`define TILE_DATA_W 32

// Words in the scratchpad, must match the address width
`define TILE_SPM_WORDS 64

// Entries per router input buffer
`define TILE_IN_FIFO_DEPTH 2

`endif

// ==== tile_pkg.sv ====
////////////////////////////////////////////////////////////
// Shared types of the mesh tile
// Router ports, flit opcodes, chimney states and the flit
////////////////////////////////////////////////////////////

`include "tile_cfg.svh"

package tile_pkg;

  // Router port index
  typedef enum logic [2:0] {
    North = 3'd0,
    East  = 3'd1,
    South = 3'd2,
    West  = 3'd3,
    Eject = 3'd4
  } port_e;

  // Flit opcode
  typedef enum logic [1:0] {
    RD_REQ = 2'd0,
    WR_REQ = 2'd1,
    RD_RSP = 2'd2,
    WR_RSP = 2'd3
  } flit_kind_e;

  // Core side of the chimney
  typedef enum logic [1:0] {
    IDLE,
    SEND,
    WAIT_RSP,
    ACK
  } chimney_state_e;

  typedef struct packed {
    logic [`TILE_COORD_W-1:0] dst_x;
    logic [`TILE_COORD_W-1:0] dst_y;
    logic [`TILE_COORD_W-1:0] src_x;
    logic [`TILE_COORD_W-1:0] src_y;
    flit_kind_e               kind;
    logic [`TILE_ADDR_W-1:0]  addr;
    logic [`TILE_DATA_W-1:0]  data;
  } flit_t;

endpackage

// ==== tile_scratchpad.sv ====
////////////////////////////////////////////////////////////
// Word-addressed scratchpad reached by remote tiles
// Single port, write on the request edge, read data one cycle later
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "tile_cfg.svh"

module tile_scratchpad (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    en_i,
  input  logic                    we_i,
  input  logic [`TILE_ADDR_W-1:0] addr_i,
  input  logic [`TILE_DATA_W-1:0] wdata_i,
  output logic [`TILE_DATA_W-1:0] rdata_o
);

  logic [`TILE_DATA_W-1:0] mem_q [`TILE_SPM_WORDS];
  logic [`TILE_DATA_W-1:0] rdata_q;

  always_ff @(posedge clk_i) begin
    if (en_i && we_i) begin
      mem_q[addr_i] <= wdata_i;
    end
  end

  // Registered read port
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rdata_q <= '0;
    end else if (en_i && !we_i) begin
      rdata_q <= mem_q[addr_i];
    end
  end

  assign rdata_o = rdata_q;

endmodule

// ==== noc_router.sv ====
////////////////////////////////////////////////////////////
// Five-port mesh router with XY routing
// Buffered inputs, round-robin grant per output
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "tile_cfg.svh"

module noc_router
  import tile_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic [`TILE_COORD_W-1:0] id_x_i,
  input  logic [`TILE_COORD_W-1:0] id_y_i,
  input  flit_t [Eject:North]      in_flit_i,
  input  logic  [Eject:North]      in_valid_i,
  output logic  [Eject:North]      in_ready_o,
  output flit_t [Eject:North]      out_flit_o,
  output logic  [Eject:North]      out_valid_o,
  input  logic  [Eject:North]      out_ready_i
);

  localparam int NumPorts = 5;
  localparam int Depth    = `TILE_IN_FIFO_DEPTH;
  localparam int PtrW     = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CntW     = $clog2(Depth + 1);

  flit_t               fifo_q   [NumPorts][Depth];
  logic [PtrW-1:0]     wr_ptr_q [NumPorts];
  logic [PtrW-1:0]     rd_ptr_q [NumPorts];
  logic [CntW-1:0]     cnt_q    [NumPorts];
  flit_t               head     [NumPorts];
  port_e               route    [NumPorts];
  logic [NumPorts-1:0] pop;

  port_e               gnt        [NumPorts];
  port_e               rr_q       [NumPorts];
  logic                lock_q     [NumPorts];
  port_e               lock_idx_q [NumPorts];

  function automatic logic [PtrW-1:0] ptr_inc(input logic [PtrW-1:0] ptr);
    return (ptr == PtrW'(Depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  ////////////////////////////////////////////////////////////
  // Input buffers
  ////////////////////////////////////////////////////////////

  for (genvar i = 0; i < NumPorts; i++) begin : g_in
    logic push;

    assign in_ready_o[i] = (cnt_q[i] != CntW'(Depth));
    assign push          = in_valid_i[i] && in_ready_o[i];
    assign head[i]       = fifo_q[i][rd_ptr_q[i]];

    // X first, then Y
    always_comb begin
      if (head[i].dst_x > id_x_i) route[i] = East;
      else if (head[i].dst_x < id_x_i) route[i] = West;
      else if (head[i].dst_y > id_y_i) route[i] = South;
      else if (head[i].dst_y < id_y_i) route[i] = North;
      else route[i] = Eject;
    end

    always_ff @(posedge clk_i) begin
      if (reset_i) begin
        wr_ptr_q[i] <= '0;
        rd_ptr_q[i] <= '0;
        cnt_q[i]    <= '0;
      end else begin
        if (push) wr_ptr_q[i] <= ptr_inc(wr_ptr_q[i]);
        if (pop[i]) rd_ptr_q[i] <= ptr_inc(rd_ptr_q[i]);
        cnt_q[i] <= cnt_q[i] + CntW'(push) - CntW'(pop[i]);
      end
    end

    always_ff @(posedge clk_i) begin
      if (push) fifo_q[i][wr_ptr_q[i]] <= in_flit_i[i];
    end
  end

  ////////////////////////////////////////////////////////////
  // Output arbitration
  ////////////////////////////////////////////////////////////

  for (genvar o = 0; o < NumPorts; o++) begin : g_out
    logic [NumPorts-1:0] req;
    port_e               pick;
    logic                found;

    always_comb begin
      int idx;
      for (int i = 0; i < NumPorts; i++) begin
        req[i] = (cnt_q[i] != '0) && (route[i] == port_e'(o));
      end
      pick  = rr_q[o];
      found = 1'b0;
      // Search starting at the round-robin pointer
      for (int k = 0; k < NumPorts; k++) begin
        idx = (int'(rr_q[o]) + k) % NumPorts;
        if (!found && req[idx]) begin
          pick  = port_e'(idx);
          found = 1'b1;
        end
      end
    end

    // A stalled grant stays put so the flit is stable
    assign gnt[o]         = lock_q[o] ? lock_idx_q[o] : pick;
    assign out_valid_o[o] = lock_q[o] || found;
    assign out_flit_o[o]  = head[gnt[o]];

    always_ff @(posedge clk_i) begin
      if (reset_i) begin
        rr_q[o]       <= North;
        lock_q[o]     <= 1'b0;
        lock_idx_q[o] <= North;
      end else if (out_valid_o[o] && out_ready_i[o]) begin
        rr_q[o]   <= (gnt[o] == Eject) ? North : port_e'(gnt[o] + 1);
        lock_q[o] <= 1'b0;
      end else if (out_valid_o[o]) begin
        lock_q[o]     <= 1'b1;
        lock_idx_q[o] <= gnt[o];
      end
    end
  end

  // Pop the granted input on a completed output handshake
  always_comb begin
    pop = '0;
    for (int o = 0; o < NumPorts; o++) begin
      if (out_valid_o[o] && out_ready_i[o]) pop[gnt[o]] = 1'b1;
    end
  end

endmodule

// ==== noc_chimney.sv ====
////////////////////////////////////////////////////////////
// Network interface between core port, scratchpad and router
// Connects to the router Eject port in both directions
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "tile_cfg.svh"

module noc_chimney
  import tile_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic [`TILE_COORD_W-1:0] id_x_i,
  input  logic [`TILE_COORD_W-1:0] id_y_i,
  // Core port, four-phase
  input  logic                     req_i,
  input  logic                     we_i,
  input  logic [`TILE_COORD_W-1:0] dst_x_i,
  input  logic [`TILE_COORD_W-1:0] dst_y_i,
  input  logic [`TILE_ADDR_W-1:0]  addr_i,
  input  logic [`TILE_DATA_W-1:0]  wdata_i,
  output logic                     ack_o,
  output logic [`TILE_DATA_W-1:0]  rdata_o,
  // Router Eject port
  input  flit_t                    ej_flit_i,
  input  logic                     ej_valid_i,
  output logic                     ej_ready_o,
  output flit_t                    inj_flit_o,
  output logic                     inj_valid_o,
  input  logic                     inj_ready_i,
  // Scratchpad
  output logic                     spm_en_o,
  output logic                     spm_we_o,
  output logic [`TILE_ADDR_W-1:0]  spm_addr_o,
  output logic [`TILE_DATA_W-1:0]  spm_wdata_o,
  input  logic [`TILE_DATA_W-1:0]  spm_rdata_i
);

  chimney_state_e          state_q, state_d;
  flit_t                   core_flit_q, acc_flit_q, rsp_flit_q;
  logic [`TILE_DATA_W-1:0] rdata_q;
  logic                    acc_q, cap_q, rsp_valid_q, busy;
  logic                    inj_lock_q, inj_sel_rsp_q, sel_rsp;
  logic                    inj_hs, ej_hs, ej_is_req, rsp_match;

  ////////////////////////////////////////////////////////////
  // Eject side and scratchpad access
  ////////////////////////////////////////////////////////////

  // One remote access at a time
  assign busy       = acc_q || cap_q || rsp_valid_q;
  assign ej_ready_o = !busy;
  assign ej_hs      = ej_valid_i && ej_ready_o;
  assign ej_is_req  = (ej_flit_i.kind == RD_REQ) || (ej_flit_i.kind == WR_REQ);
  assign rsp_match  = ej_hs && (state_q == WAIT_RSP) &&
                      (ej_flit_i.kind == ((core_flit_q.kind == WR_REQ) ? WR_RSP : RD_RSP));

  assign spm_en_o    = acc_q;
  assign spm_we_o    = acc_q && (acc_flit_q.kind == WR_REQ);
  assign spm_addr_o  = acc_flit_q.addr;
  assign spm_wdata_o = acc_flit_q.data;

  ////////////////////////////////////////////////////////////
  // Inject side, response has priority
  ////////////////////////////////////////////////////////////

  assign sel_rsp     = inj_lock_q ? inj_sel_rsp_q : rsp_valid_q;
  assign inj_valid_o = sel_rsp ? rsp_valid_q : (state_q == SEND);
  assign inj_flit_o  = sel_rsp ? rsp_flit_q : core_flit_q;
  assign inj_hs      = inj_valid_o && inj_ready_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:     if (req_i) state_d = SEND;
      SEND:     if (inj_hs && !sel_rsp) state_d = WAIT_RSP;
      WAIT_RSP: if (rsp_match) state_d = ACK;
      ACK:      if (!req_i) state_d = IDLE;
      default:  state_d = IDLE;
    endcase
  end

  assign ack_o   = (state_q == ACK);
  assign rdata_o = rdata_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q       <= IDLE;
      acc_q         <= 1'b0;
      cap_q         <= 1'b0;
      rsp_valid_q   <= 1'b0;
      inj_lock_q    <= 1'b0;
      inj_sel_rsp_q <= 1'b0;
    end else begin
      state_q <= state_d;
      acc_q   <= ej_hs && ej_is_req;
      cap_q   <= acc_q;
      if (cap_q) rsp_valid_q <= 1'b1;
      else if (inj_hs && sel_rsp) rsp_valid_q <= 1'b0;
      if (inj_hs) begin
        inj_lock_q <= 1'b0;
      end else if (inj_valid_o) begin
        inj_lock_q    <= 1'b1;
        inj_sel_rsp_q <= sel_rsp;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && req_i) begin
      core_flit_q.dst_x <= dst_x_i;
      core_flit_q.dst_y <= dst_y_i;
      core_flit_q.src_x <= id_x_i;
      core_flit_q.src_y <= id_y_i;
      core_flit_q.kind  <= we_i ? WR_REQ : RD_REQ;
      core_flit_q.addr  <= addr_i;
      core_flit_q.data  <= we_i ? wdata_i : '0;
    end
    if (rsp_match) rdata_q <= (ej_flit_i.kind == RD_RSP) ? ej_flit_i.data : '0;
    if (ej_hs && ej_is_req) acc_flit_q <= ej_flit_i;
    // Response goes back to the requester
    if (cap_q) begin
      rsp_flit_q.dst_x <= acc_flit_q.src_x;
      rsp_flit_q.dst_y <= acc_flit_q.src_y;
      rsp_flit_q.src_x <= id_x_i;
      rsp_flit_q.src_y <= id_y_i;
      rsp_flit_q.kind  <= (acc_flit_q.kind == WR_REQ) ? WR_RSP : RD_RSP;
      rsp_flit_q.addr  <= acc_flit_q.addr;
      rsp_flit_q.data  <= (acc_flit_q.kind == WR_REQ) ? '0 : spm_rdata_i;
    end
  end

endmodule

// ==== cluster_tile.sv ====
////////////////////////////////////////////////////////////
// Mesh tile with router, chimney and scratchpad
// Exposes the four mesh links and the local core port
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "tile_cfg.svh"

module cluster_tile
  import tile_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic [`TILE_COORD_W-1:0] id_x_i,
  input  logic [`TILE_COORD_W-1:0] id_y_i,
  // Core port
  input  logic                     req_i,
  input  logic                     we_i,
  input  logic [`TILE_COORD_W-1:0] dst_x_i,
  input  logic [`TILE_COORD_W-1:0] dst_y_i,
  input  logic [`TILE_ADDR_W-1:0]  addr_i,
  input  logic [`TILE_DATA_W-1:0]  wdata_i,
  output logic                     ack_o,
  output logic [`TILE_DATA_W-1:0]  rdata_o,
  // Mesh links
  input  flit_t [West:North]       flit_i,
  input  logic  [West:North]       valid_i,
  output logic  [West:North]       ready_o,
  output flit_t [West:North]       flit_o,
  output logic  [West:North]       valid_o,
  input  logic  [West:North]       ready_i
);

  flit_t [Eject:North]     rt_in_flit, rt_out_flit;
  logic  [Eject:North]     rt_in_valid, rt_in_ready, rt_out_valid, rt_out_ready;
  logic                    spm_en, spm_we;
  logic [`TILE_ADDR_W-1:0] spm_addr;
  logic [`TILE_DATA_W-1:0] spm_wdata, spm_rdata;

  assign rt_in_flit[West:North]   = flit_i;
  assign rt_in_valid[West:North]  = valid_i;
  assign ready_o                  = rt_in_ready[West:North];
  assign flit_o                   = rt_out_flit[West:North];
  assign valid_o                  = rt_out_valid[West:North];
  assign rt_out_ready[West:North] = ready_i;

  noc_router u_router (
    .clk_i,
    .reset_i,
    .id_x_i,
    .id_y_i,
    .in_flit_i  (rt_in_flit),
    .in_valid_i (rt_in_valid),
    .in_ready_o (rt_in_ready),
    .out_flit_o (rt_out_flit),
    .out_valid_o(rt_out_valid),
    .out_ready_i(rt_out_ready)
  );

  // Eject port of the router faces the chimney
  noc_chimney u_chimney (
    .clk_i,
    .reset_i,
    .id_x_i,
    .id_y_i,
    .req_i,
    .we_i,
    .dst_x_i,
    .dst_y_i,
    .addr_i,
    .wdata_i,
    .ack_o,
    .rdata_o,
    .ej_flit_i  (rt_out_flit[Eject]),
    .ej_valid_i (rt_out_valid[Eject]),
    .ej_ready_o (rt_out_ready[Eject]),
    .inj_flit_o (rt_in_flit[Eject]),
    .inj_valid_o(rt_in_valid[Eject]),
    .inj_ready_i(rt_in_ready[Eject]),
    .spm_en_o   (spm_en),
    .spm_we_o   (spm_we),
    .spm_addr_o (spm_addr),
    .spm_wdata_o(spm_wdata),
    .spm_rdata_i(spm_rdata)
  );

  tile_scratchpad u_spm (
    .clk_i,
    .reset_i,
    .en_i   (spm_en),
    .we_i   (spm_we),
    .addr_i (spm_addr),
    .wdata_i(spm_wdata),
    .rdata_o(spm_rdata)
  );

endmodule

// ==== tb_cluster_tile.sv ====
////////////////////////////////////////////////////////////
// Directed testbench for the mesh tile at position (1,1)
// Drives mesh links and the core port, checks flits and words
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "tile_cfg.svh"

module tb_cluster_tile
  import tile_pkg::*;
();

  localparam int ResetCycles   = 8;
  localparam int WaitLimit     = 40;
  // Flits and core accesses issued over all tests
  localparam int NumOps        = 15;
  localparam int TimeoutCycles = 40 * NumOps + ResetCycles;

  logic                     clk;
  logic                     reset;
  logic                     req;
  logic                     we;
  logic [`TILE_COORD_W-1:0] dst_x;
  logic [`TILE_COORD_W-1:0] dst_y;
  logic [`TILE_ADDR_W-1:0]  addr;
  logic [`TILE_DATA_W-1:0]  wdata;
  logic                     ack;
  logic [`TILE_DATA_W-1:0]  rdata;
  flit_t [West:North]       in_flit;
  logic  [West:North]       in_valid;
  logic  [West:North]       in_ready;
  flit_t [West:North]       out_flit;
  logic  [West:North]       out_valid;
  logic  [West:North]       out_ready;

  logic [15:0] lfsr_q;
  int          errors;
  int          checks;
  int          tests_run;
  int          cycle_cnt;
  string       cur_test;
  logic        watch_mesh;
  logic        mesh_seen;

  cluster_tile u_cluster_tile (
    .clk_i  (clk),
    .reset_i(reset),
    .id_x_i (2'd1),
    .id_y_i (2'd1),
    .req_i  (req),
    .we_i   (we),
    .dst_x_i(dst_x),
    .dst_y_i(dst_y),
    .addr_i (addr),
    .wdata_i(wdata),
    .ack_o  (ack),
    .rdata_o(rdata),
    .flit_i (in_flit),
    .valid_i(in_valid),
    .ready_o(in_ready),
    .flit_o (out_flit),
    .valid_o(out_valid),
    .ready_i(out_ready)
  );

  always #2 clk = ~clk;

  // Any mesh output going valid while watched
  always @(negedge clk) begin
    if (watch_mesh && |out_valid) mesh_seen = 1'b1;
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  // Taps 16,14,13,11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [`TILE_DATA_W-1:0] lfsr_word();
    logic [`TILE_DATA_W-1:0] w;
    w = '0;
    for (int b = 0; b < `TILE_DATA_W; b++) begin
      lfsr_q = lfsr_step(lfsr_q);
      w      = {w[`TILE_DATA_W-2:0], lfsr_q[0]};
    end
    return w;
  endfunction

  function automatic flit_t make_flit(input logic [`TILE_COORD_W-1:0] dx, dy, sx, sy,
                                      input flit_kind_e kind,
                                      input logic [`TILE_ADDR_W-1:0] a,
                                      input logic [`TILE_DATA_W-1:0] d);
    flit_t f;
    f.dst_x = dx;
    f.dst_y = dy;
    f.src_x = sx;
    f.src_y = sy;
    f.kind  = kind;
    f.addr  = a;
    f.data  = d;
    return f;
  endfunction

  task automatic check_flit(input string what, input flit_t exp, input flit_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("MISMATCH %s %s: expected %h, actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic check_word(input string what, input logic [`TILE_DATA_W-1:0] exp,
                            input logic [`TILE_DATA_W-1:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("MISMATCH %s %s: expected %h, actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("MISMATCH %s %s: expected %b, actual %b", cur_test, what, exp, act);
    end
  endtask

  // Called on a falling edge, returns on a falling edge
  task automatic send_flit(input port_e p, input flit_t f);
    int n;
    n           = 0;
    in_flit[p]  = f;
    in_valid[p] = 1'b1;
    while (!in_ready[p] && n < WaitLimit) begin
      @(negedge clk);
      n++;
    end
    if (!in_ready[p]) begin
      errors++;
      $display("%s: %s input never accepted the flit", cur_test, p.name());
    end
    @(negedge clk);
    in_valid[p] = 1'b0;
  endtask

  task automatic expect_flit(input port_e p, input flit_t exp);
    int n;
    n = 0;
    while (!out_valid[p] && n < WaitLimit) begin
      @(negedge clk);
      n++;
    end
    if (!out_valid[p]) begin
      errors++;
      $display("%s: no flit left the %s output", cur_test, p.name());
    end else begin
      check_flit({p.name(), " flit"}, exp, out_flit[p]);
    end
    @(negedge clk);
  endtask

  task automatic core_start(input logic w, input logic [`TILE_COORD_W-1:0] dx, dy,
                            input logic [`TILE_ADDR_W-1:0] a,
                            input logic [`TILE_DATA_W-1:0] d);
    req   = 1'b1;
    we    = w;
    dst_x = dx;
    dst_y = dy;
    addr  = a;
    wdata = d;
  endtask

  // Remaining three phases of the core handshake
  task automatic core_finish(input logic [`TILE_DATA_W-1:0] exp_rdata);
    int n;
    n = 0;
    while (!ack && n < WaitLimit) begin
      @(negedge clk);
      n++;
    end
    if (!ack) begin
      errors++;
      $display("%s: ack never rose on the core port", cur_test);
    end else begin
      check_word("rdata", exp_rdata, rdata);
    end
    req = 1'b0;
    n   = 0;
    @(negedge clk);
    while (ack && n < WaitLimit) begin
      @(negedge clk);
      n++;
    end
    if (ack) begin
      errors++;
      $display("%s: ack stayed high after req dropped", cur_test);
    end
  endtask

  task automatic finish_test(input int errs_at_start);
    tests_run++;
    $display("%s: finished, %0d failures", cur_test, errors - errs_at_start);
  endtask

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////

  task automatic check_reset_state();
    int e0;
    e0       = errors;
    cur_test = "reset_state";
    for (int p = 0; p < 4; p++) begin
      check_bit($sformatf("valid_o[%0d]", p), 1'b0, out_valid[p]);
      check_bit($sformatf("ready_o[%0d]", p), 1'b1, in_ready[p]);
    end
    check_bit("ack_o", 1'b0, ack);
    finish_test(e0);
  endtask

  task automatic route_pass_through();
    int    e0;
    flit_t f;
    e0       = errors;
    cur_test = "pass_through";
    f = make_flit(2'd3, 2'd1, 2'd0, 2'd1, RD_REQ, 6'h05, lfsr_word());
    send_flit(West, f);
    expect_flit(East, f);
    f = make_flit(2'd0, 2'd2, 2'd3, 2'd0, WR_REQ, 6'h11, lfsr_word());
    send_flit(East, f);
    expect_flit(West, f);
    f = make_flit(2'd1, 2'd0, 2'd1, 2'd3, RD_RSP, 6'h2a, lfsr_word());
    send_flit(South, f);
    expect_flit(North, f);
    f = make_flit(2'd1, 2'd3, 2'd2, 2'd0, WR_RSP, 6'h3f, lfsr_word());
    send_flit(North, f);
    expect_flit(South, f);
    finish_test(e0);
  endtask

  task automatic access_remote_spm();
    int                      e0;
    logic [`TILE_DATA_W-1:0] w;
    e0       = errors;
    cur_test = "remote_spm";
    w        = lfsr_word();
    send_flit(South, make_flit(2'd1, 2'd1, 2'd1, 2'd3, WR_REQ, 6'h0c, w));
    expect_flit(South, make_flit(2'd1, 2'd3, 2'd1, 2'd1, WR_RSP, 6'h0c, '0));
    send_flit(South, make_flit(2'd1, 2'd1, 2'd1, 2'd3, RD_REQ, 6'h0c, '0));
    expect_flit(South, make_flit(2'd1, 2'd3, 2'd1, 2'd1, RD_RSP, 6'h0c, w));
    finish_test(e0);
  endtask

  task automatic access_remote_tile();
    int                      e0;
    logic [`TILE_DATA_W-1:0] w;
    logic [`TILE_DATA_W-1:0] d;
    e0       = errors;
    cur_test = "remote_tile";
    w        = lfsr_word();
    d        = lfsr_word();
    core_start(1'b1, 2'd2, 2'd1, 6'h21, w);
    expect_flit(East, make_flit(2'd2, 2'd1, 2'd1, 2'd1, WR_REQ, 6'h21, w));
    // No ack until the response is back
    check_bit("ack before write response", 1'b0, ack);
    send_flit(East, make_flit(2'd1, 2'd1, 2'd2, 2'd1, WR_RSP, 6'h21, '0));
    core_finish('0);
    core_start(1'b0, 2'd2, 2'd1, 6'h22, '0);
    expect_flit(East, make_flit(2'd2, 2'd1, 2'd1, 2'd1, RD_REQ, 6'h22, '0));
    check_bit("ack before read response", 1'b0, ack);
    send_flit(East, make_flit(2'd1, 2'd1, 2'd2, 2'd1, RD_RSP, 6'h22, d));
    core_finish(d);
    finish_test(e0);
  endtask

  task automatic access_own_tile();
    int                      e0;
    logic [`TILE_DATA_W-1:0] w;
    e0         = errors;
    cur_test   = "own_tile";
    w          = lfsr_word();
    mesh_seen  = 1'b0;
    watch_mesh = 1'b1;
    core_start(1'b1, 2'd1, 2'd1, 6'h30, w);
    core_finish('0);
    core_start(1'b0, 2'd1, 2'd1, 6'h30, '0);
    core_finish(w);
    watch_mesh = 1'b0;
    check_bit("mesh valid seen", 1'b0, mesh_seen);
    finish_test(e0);
  endtask

  task automatic apply_back_pressure();
    int    e0;
    flit_t f1, f2, f3;
    e0       = errors;
    cur_test = "back_pressure";
    f1 = make_flit(2'd3, 2'd1, 2'd0, 2'd1, WR_REQ, 6'h01, lfsr_word());
    f2 = make_flit(2'd3, 2'd1, 2'd0, 2'd1, WR_REQ, 6'h02, lfsr_word());
    f3 = make_flit(2'd3, 2'd1, 2'd0, 2'd1, WR_REQ, 6'h03, lfsr_word());
    out_ready[East] = 1'b0;
    send_flit(West, f1);
    send_flit(West, f2);
    // Third flit waits at a full buffer
    in_flit[West]  = f3;
    in_valid[West] = 1'b1;
    repeat (3) @(negedge clk);
    check_bit("West ready_o", 1'b0, in_ready[West]);
    check_bit("East valid_o", 1'b1, out_valid[East]);
    check_flit("East held flit", f1, out_flit[East]);
    out_ready[East] = 1'b1;
    fork
      send_flit(West, f3);
      begin
        expect_flit(East, f1);
        expect_flit(East, f2);
        expect_flit(East, f3);
      end
    join
    finish_test(e0);
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence and timeout
  ////////////////////////////////////////////////////////////

  initial begin
    clk        = 1'b0;
    reset      = 1'b1;
    req        = 1'b0;
    we         = 1'b0;
    dst_x      = '0;
    dst_y      = '0;
    addr       = '0;
    wdata      = '0;
    in_flit    = '0;
    in_valid   = '0;
    out_ready  = '1;
    lfsr_q     = 16'd66;
    errors     = 0;
    checks     = 0;
    tests_run  = 0;
    watch_mesh = 1'b0;
    mesh_seen  = 1'b0;
    repeat (ResetCycles) @(negedge clk);
    reset = 1'b0;
    check_reset_state();
    route_pass_through();
    access_remote_spm();
    access_remote_tile();
    access_own_tile();
    apply_back_pressure();
    $display("Summary: %0d tests, %0d checks, %0d failures", tests_run, checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TimeoutCycles) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: run did not end within %0d cycles", TimeoutCycles);
    $display("Errors found");
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+.
tile_pkg.sv
tile_scratchpad.sv
noc_router.sv
noc_chimney.sv
cluster_tile.sv
tb_cluster_tile.sv
